/* common/backend_pkg.sv */
`default_nettype none

package backend_pkg;

    localparam int BUS_WIDTH      = 32;
    localparam int REG_ADDR_WIDTH = 5;
    localparam int REG_NUM        = 2 ** REG_ADDR_WIDTH;

    typedef logic [BUS_WIDTH - 1:0] bus32_t;
    typedef logic [REG_ADDR_WIDTH - 1:0] reg_addr_t;

    // operation picked by the decoder, nop also covers undecodable words
    typedef enum logic [3:0] {
        OP_NOP,
        OP_ADD,
        OP_SUB,
        OP_AND,
        OP_OR,
        OP_XOR,
        OP_SLT,
        OP_LUI,
        OP_BEQ,
        OP_BNE,
        OP_B
    } alu_op_t;

    typedef struct packed {
        bus32_t pc;
        bus32_t inst;
    } fetch_t;

    typedef struct packed {
        bus32_t    pc;
        alu_op_t   op;
        reg_addr_t rs1;
        reg_addr_t rs2;
        logic      use_imm;
        bus32_t    imm;
        reg_addr_t rd;
        logic      reg_we;
        bus32_t    branch_offset;
    } id_dispatch_t;

    typedef struct packed {
        bus32_t    pc;
        alu_op_t   op;
        bus32_t    src1;
        bus32_t    src2;
        reg_addr_t rd;
        logic      reg_we;
        bus32_t    branch_target;
    } dispatch_ex_t;

    typedef struct packed {
        bus32_t    pc;
        reg_addr_t rd;
        logic      reg_we;
        bus32_t    result;
        // taken branch or jump
        logic      redirect;
        bus32_t    redirect_pc;
    } ex_commit_t;

    typedef struct packed {
        logic      valid;
        reg_addr_t rd;
        bus32_t    data;
    } push_forward_t;

endpackage

`default_nettype wire

/* src/regfile.sv */
`timescale 1ns/1ps
`default_nettype none

module regfile (
    input  logic                   clk,
    input  logic                   reset_i,
    input  logic                   we_i,
    input  backend_pkg::reg_addr_t waddr_i,
    input  backend_pkg::bus32_t    wdata_i,
    input  backend_pkg::reg_addr_t raddr1_i,
    input  backend_pkg::reg_addr_t raddr2_i,
    output backend_pkg::bus32_t    rdata1_o,
    output backend_pkg::bus32_t    rdata2_o
);

    backend_pkg::bus32_t regs_q [backend_pkg::REG_NUM];

    always_ff @(posedge clk) begin
        if (reset_i) begin
            for (int i = 0; i < backend_pkg::REG_NUM; i++) begin
                regs_q[i] <= '0;
            end
        end else if (we_i && waddr_i != '0) begin
            regs_q[waddr_i] <= wdata_i;
        end
    end

    // same-cycle writes reach dispatch through the commit forward
    assign rdata1_o = (raddr1_i == '0) ? '0 : regs_q[raddr1_i];
    assign rdata2_o = (raddr2_i == '0) ? '0 : regs_q[raddr2_i];

endmodule

`default_nettype wire

/* src/decoder.sv */
`timescale 1ns/1ps
`default_nettype none

module decoder #(
    parameter int QUEUE_DEPTH = 4,
    localparam int CNT_W = $clog2(QUEUE_DEPTH + 1),
    localparam int PTR_W = $clog2(QUEUE_DEPTH)
) (
    input  logic                     clk,
    input  logic                     reset_i,
    input  logic                     flush_i,
    input  logic                     fetch_valid_i,
    input  backend_pkg::fetch_t      fetch_i,
    output logic [CNT_W - 1:0]       credit_return_o,
    output logic                     id_valid_o,
    output backend_pkg::id_dispatch_t id_o
);

    // loongarch major opcodes
    localparam logic [16:0] OPC_ADD_W   = 17'h00020;
    localparam logic [16:0] OPC_SUB_W   = 17'h00022;
    localparam logic [16:0] OPC_SLT     = 17'h00024;
    localparam logic [16:0] OPC_AND     = 17'h00029;
    localparam logic [16:0] OPC_OR      = 17'h0002a;
    localparam logic [16:0] OPC_XOR     = 17'h0002b;
    localparam logic [9:0]  OPC_ADDI_W  = 10'h00a;
    localparam logic [6:0]  OPC_LU12I_W = 7'h0a;
    localparam logic [5:0]  OPC_B       = 6'h14;
    localparam logic [5:0]  OPC_BEQ     = 6'h16;
    localparam logic [5:0]  OPC_BNE     = 6'h17;

    backend_pkg::fetch_t  queue_q [QUEUE_DEPTH];
    logic [PTR_W - 1:0]   head_q;
    logic [PTR_W - 1:0]   tail_q;
    logic [CNT_W - 1:0]   count_q;
    logic                 push;
    logic                 pop;
    backend_pkg::fetch_t  head;
    backend_pkg::bus32_t  inst;
    backend_pkg::alu_op_t op3r;

    assign push = fetch_valid_i && !flush_i;
    assign pop  = (count_q != '0) && !flush_i;
    assign head = queue_q[head_q];
    assign inst = head.inst;

    assign id_valid_o = (count_q != '0);
    // on flush every queued entry plus a dropped transfer goes back
    assign credit_return_o = flush_i ? count_q + CNT_W'(fetch_valid_i) : CNT_W'(pop);

    always_ff @(posedge clk) begin
        if (reset_i || flush_i) begin
            head_q  <= '0;
            tail_q  <= '0;
            count_q <= '0;
        end else begin
            if (push) begin
                tail_q <= (tail_q == PTR_W'(QUEUE_DEPTH - 1)) ? '0 : tail_q + 1'b1;
            end
            if (pop) begin
                head_q <= (head_q == PTR_W'(QUEUE_DEPTH - 1)) ? '0 : head_q + 1'b1;
            end
            count_q <= count_q + CNT_W'(push) - CNT_W'(pop);
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            queue_q[tail_q] <= fetch_i;
        end
    end

    always_comb begin
        case (inst[31:15])
            OPC_ADD_W: op3r = backend_pkg::OP_ADD;
            OPC_SUB_W: op3r = backend_pkg::OP_SUB;
            OPC_SLT:   op3r = backend_pkg::OP_SLT;
            OPC_AND:   op3r = backend_pkg::OP_AND;
            OPC_OR:    op3r = backend_pkg::OP_OR;
            OPC_XOR:   op3r = backend_pkg::OP_XOR;
            default:   op3r = backend_pkg::OP_NOP;
        endcase
    end

    always_comb begin
        id_o     = '0;
        id_o.pc  = head.pc;
        id_o.op  = backend_pkg::OP_NOP;
        id_o.rs1 = inst[9:5];
        id_o.rs2 = inst[14:10];
        id_o.rd  = inst[4:0];
        if (op3r != backend_pkg::OP_NOP) begin
            id_o.op     = op3r;
            id_o.reg_we = 1'b1;
        end else if (inst[31:22] == OPC_ADDI_W) begin
            id_o.op      = backend_pkg::OP_ADD;
            id_o.use_imm = 1'b1;
            id_o.imm     = {{20{inst[21]}}, inst[21:10]};
            id_o.reg_we  = 1'b1;
        end else if (inst[31:25] == OPC_LU12I_W) begin
            id_o.op      = backend_pkg::OP_LUI;
            id_o.use_imm = 1'b1;
            id_o.imm     = {{12{inst[24]}}, inst[24:5]};
            id_o.reg_we  = 1'b1;
        end else if (inst[31:26] == OPC_BEQ || inst[31:26] == OPC_BNE) begin
            // second compare operand sits in the rd field
            id_o.op            = (inst[26]) ? backend_pkg::OP_BNE : backend_pkg::OP_BEQ;
            id_o.rs2           = inst[4:0];
            id_o.branch_offset = {{14{inst[25]}}, inst[25:10], 2'b00};
        end else if (inst[31:26] == OPC_B) begin
            id_o.op            = backend_pkg::OP_B;
            id_o.branch_offset = {{4{inst[9]}}, inst[9:0], inst[25:10], 2'b00};
        end
    end

endmodule

`default_nettype wire

/* src/dispatch.sv */
`timescale 1ns/1ps
`default_nettype none

module dispatch (
    input  logic                       clk,
    input  logic                       reset_i,
    input  logic                       flush_i,
    input  logic                       id_valid_i,
    input  backend_pkg::id_dispatch_t  id_i,
    input  backend_pkg::push_forward_t ex_pf_i,
    input  backend_pkg::push_forward_t wb_pf_i,
    input  backend_pkg::bus32_t        rdata1_i,
    input  backend_pkg::bus32_t        rdata2_i,
    output backend_pkg::reg_addr_t     raddr1_o,
    output backend_pkg::reg_addr_t     raddr2_o,
    output logic                       ex_valid_o,
    output backend_pkg::dispatch_ex_t  ex_o
);

    backend_pkg::bus32_t       src1;
    backend_pkg::bus32_t       src2_reg;
    backend_pkg::dispatch_ex_t ex_d;

    // youngest producer wins, r0 never forwards
    function automatic backend_pkg::bus32_t resolve(
        input backend_pkg::reg_addr_t     addr,
        input backend_pkg::bus32_t        rdata,
        input backend_pkg::push_forward_t ex_pf,
        input backend_pkg::push_forward_t wb_pf
    );
        backend_pkg::bus32_t value;
        value = rdata;
        if (addr != '0 && ex_pf.valid && ex_pf.rd == addr) begin
            value = ex_pf.data;
        end else if (addr != '0 && wb_pf.valid && wb_pf.rd == addr) begin
            value = wb_pf.data;
        end
        return value;
    endfunction

    assign raddr1_o = id_i.rs1;
    assign raddr2_o = id_i.rs2;

    assign src1     = resolve(id_i.rs1, rdata1_i, ex_pf_i, wb_pf_i);
    assign src2_reg = resolve(id_i.rs2, rdata2_i, ex_pf_i, wb_pf_i);

    always_comb begin
        ex_d.pc            = id_i.pc;
        ex_d.op            = id_i.op;
        ex_d.src1          = src1;
        ex_d.src2          = id_i.use_imm ? id_i.imm : src2_reg;
        ex_d.rd            = id_i.rd;
        ex_d.reg_we        = id_i.reg_we;
        ex_d.branch_target = id_i.pc + id_i.branch_offset;
    end

    always_ff @(posedge clk) begin
        if (reset_i || flush_i) begin
            ex_valid_o <= 1'b0;
        end else begin
            ex_valid_o <= id_valid_i;
        end
    end

    always_ff @(posedge clk) begin
        ex_o <= ex_d;
    end

endmodule

`default_nettype wire

/* src/execute.sv */
`timescale 1ns/1ps
`default_nettype none

module execute (
    input  logic                       clk,
    input  logic                       reset_i,
    input  logic                       flush_i,
    input  logic                       ex_valid_i,
    input  backend_pkg::dispatch_ex_t  ex_i,
    output backend_pkg::push_forward_t ex_pf_o,
    output logic                       commit_valid_o,
    output backend_pkg::ex_commit_t    commit_o
);

    backend_pkg::bus32_t     result;
    logic                    taken;
    backend_pkg::ex_commit_t commit_d;

    always_comb begin
        case (ex_i.op)
            backend_pkg::OP_ADD: result = ex_i.src1 + ex_i.src2;
            backend_pkg::OP_SUB: result = ex_i.src1 - ex_i.src2;
            backend_pkg::OP_AND: result = ex_i.src1 & ex_i.src2;
            backend_pkg::OP_OR:  result = ex_i.src1 | ex_i.src2;
            backend_pkg::OP_XOR: result = ex_i.src1 ^ ex_i.src2;
            backend_pkg::OP_SLT: begin
                result = {31'b0, $signed(ex_i.src1) < $signed(ex_i.src2)};
            end
            backend_pkg::OP_LUI: result = ex_i.src2 << 12;
            default:             result = '0;
        endcase
    end

    // every branch was predicted not taken
    always_comb begin
        case (ex_i.op)
            backend_pkg::OP_BEQ: taken = (ex_i.src1 == ex_i.src2);
            backend_pkg::OP_BNE: taken = (ex_i.src1 != ex_i.src2);
            backend_pkg::OP_B:   taken = 1'b1;
            default:             taken = 1'b0;
        endcase
    end

    assign ex_pf_o.valid = ex_valid_i && ex_i.reg_we;
    assign ex_pf_o.rd    = ex_i.rd;
    assign ex_pf_o.data  = result;

    always_comb begin
        commit_d.pc          = ex_i.pc;
        commit_d.rd          = ex_i.rd;
        commit_d.reg_we      = ex_i.reg_we;
        commit_d.result      = result;
        commit_d.redirect    = taken;
        commit_d.redirect_pc = ex_i.branch_target;
    end

    always_ff @(posedge clk) begin
        if (reset_i || flush_i) begin
            commit_valid_o <= 1'b0;
        end else begin
            commit_valid_o <= ex_valid_i;
        end
    end

    always_ff @(posedge clk) begin
        commit_o <= commit_d;
    end

endmodule

`default_nettype wire

/* src/ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

module ctrl (
    input  logic                       commit_valid_i,
    input  backend_pkg::ex_commit_t    commit_i,
    output logic                       flush_o,
    output backend_pkg::push_forward_t wb_pf_o,
    output logic                       we_o,
    output backend_pkg::reg_addr_t     waddr_o,
    output backend_pkg::bus32_t        wdata_o,
    output logic                       commit_valid_o,
    output backend_pkg::bus32_t        commit_pc_o,
    output backend_pkg::reg_addr_t     commit_rd_o,
    output backend_pkg::bus32_t        commit_data_o,
    output logic                       redirect_valid_o,
    output backend_pkg::bus32_t        redirect_pc_o
);

    // writes to r0 are dropped here
    assign we_o    = commit_valid_i && commit_i.reg_we && (commit_i.rd != '0);
    assign waddr_o = commit_i.rd;
    assign wdata_o = commit_i.result;

    assign wb_pf_o.valid = we_o;
    assign wb_pf_o.rd    = commit_i.rd;
    assign wb_pf_o.data  = commit_i.result;

    // no register write reports rd 0 and value 0
    assign commit_valid_o = commit_valid_i;
    assign commit_pc_o    = commit_i.pc;
    assign commit_rd_o    = we_o ? commit_i.rd : '0;
    assign commit_data_o  = we_o ? commit_i.result : '0;

    assign flush_o          = commit_valid_i && commit_i.redirect;
    assign redirect_valid_o = flush_o;
    assign redirect_pc_o    = commit_i.redirect_pc;

endmodule

`default_nettype wire

/* src/backend_top.sv */
`timescale 1ns/1ps
`default_nettype none

module backend_top #(
    parameter int QUEUE_DEPTH = 4,
    localparam int CNT_W = $clog2(QUEUE_DEPTH + 1)
) (
    input  logic                   clk,
    input  logic                   reset_i,
    input  logic                   fetch_valid_i,
    input  backend_pkg::fetch_t    fetch_i,
    output logic [CNT_W - 1:0]     credit_return_o,
    output logic                   commit_valid_o,
    output backend_pkg::bus32_t    commit_pc_o,
    output backend_pkg::reg_addr_t commit_rd_o,
    output backend_pkg::bus32_t    commit_data_o,
    output logic                   redirect_valid_o,
    output backend_pkg::bus32_t    redirect_pc_o
);

    logic                       flush;
    logic                       id_valid;
    backend_pkg::id_dispatch_t  id;
    backend_pkg::reg_addr_t     raddr1;
    backend_pkg::reg_addr_t     raddr2;
    backend_pkg::bus32_t        rdata1;
    backend_pkg::bus32_t        rdata2;
    logic                       ex_valid;
    backend_pkg::dispatch_ex_t  ex;
    backend_pkg::push_forward_t ex_pf;
    backend_pkg::push_forward_t wb_pf;
    logic                       ex_commit_valid;
    backend_pkg::ex_commit_t    ex_commit;
    logic                       reg_we;
    backend_pkg::reg_addr_t     reg_waddr;
    backend_pkg::bus32_t        reg_wdata;

    decoder #(
        .QUEUE_DEPTH(QUEUE_DEPTH)
    ) u_decoder (
        .clk,
        .reset_i,
        .flush_i(flush),
        .fetch_valid_i,
        .fetch_i,
        .credit_return_o,
        .id_valid_o(id_valid),
        .id_o(id)
    );

    dispatch u_dispatch (
        .clk,
        .reset_i,
        .flush_i(flush),
        .id_valid_i(id_valid),
        .id_i(id),
        .ex_pf_i(ex_pf),
        .wb_pf_i(wb_pf),
        .rdata1_i(rdata1),
        .rdata2_i(rdata2),
        .raddr1_o(raddr1),
        .raddr2_o(raddr2),
        .ex_valid_o(ex_valid),
        .ex_o(ex)
    );

    execute u_execute (
        .clk,
        .reset_i,
        .flush_i(flush),
        .ex_valid_i(ex_valid),
        .ex_i(ex),
        .ex_pf_o(ex_pf),
        .commit_valid_o(ex_commit_valid),
        .commit_o(ex_commit)
    );

    ctrl u_ctrl (
        .commit_valid_i(ex_commit_valid),
        .commit_i(ex_commit),
        .flush_o(flush),
        .wb_pf_o(wb_pf),
        .we_o(reg_we),
        .waddr_o(reg_waddr),
        .wdata_o(reg_wdata),
        .commit_valid_o,
        .commit_pc_o,
        .commit_rd_o,
        .commit_data_o,
        .redirect_valid_o,
        .redirect_pc_o
    );

    regfile u_regfile (
        .clk,
        .reset_i,
        .we_i(reg_we),
        .waddr_i(reg_waddr),
        .wdata_i(reg_wdata),
        .raddr1_i(raddr1),
        .raddr2_i(raddr2),
        .rdata1_o(rdata1),
        .rdata2_o(rdata2)
    );

endmodule

`default_nettype wire

/* test/tb_backend.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_backend;

    localparam int QUEUE_DEPTH = 4;
    localparam int CNT_W       = $clog2(QUEUE_DEPTH + 1);
    localparam int EXP_BASE    = 32;
    localparam int TIMEOUT     = 2000;
    localparam logic [31:0] PC_BASE = 32'h1c000000;
    localparam logic [31:0] MARKER  = 32'hffffffff;

    logic                   clk;
    logic                   reset_i;
    logic                   fetch_valid_i;
    backend_pkg::fetch_t    fetch_i;
    logic [CNT_W - 1:0]     credit_return_o;
    logic                   commit_valid_o;
    backend_pkg::bus32_t    commit_pc_o;
    backend_pkg::reg_addr_t commit_rd_o;
    backend_pkg::bus32_t    commit_data_o;
    logic                   redirect_valid_o;
    backend_pkg::bus32_t    redirect_pc_o;

    // word 0 is the program length, program from word 1, expected list at EXP_BASE
    logic [31:0] mem [0:127];

    int          errors;
    int          tests;
    int          credits;
    int          exp_idx;
    logic        fetch_enable;
    logic [31:0] fetch_pc;
    logic [15:0] lfsr;

    backend_top #(
        .QUEUE_DEPTH(QUEUE_DEPTH)
    ) dut0 (
        .clk,
        .reset_i,
        .fetch_valid_i,
        .fetch_i,
        .credit_return_o,
        .commit_valid_o,
        .commit_pc_o,
        .commit_rd_o,
        .commit_data_o,
        .redirect_valid_o,
        .redirect_pc_o
    );

    // taps 16 14 13 11
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        logic fb;
        fb = s[15] ^ s[13] ^ s[12] ^ s[10];
        return {s[14:0], fb};
    endfunction

    function automatic bit prog_has(input logic [31:0] pc);
        logic [31:0] idx;
        idx = (pc - PC_BASE) >> 2;
        return (pc >= PC_BASE) && (idx < mem[0]);
    endfunction

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // fetch model with credit tracking
    always @(posedge clk) begin
        if (reset_i) begin
            fetch_valid_i <= 1'b0;
            credits  = QUEUE_DEPTH;
            fetch_pc = PC_BASE;
        end else begin
            credits = credits + int'(credit_return_o);
            if (credits > QUEUE_DEPTH) begin
                $display("credit count out of range: %0d", credits);
                errors++;
            end
            if (redirect_valid_o) begin
                fetch_pc = redirect_pc_o;
            end
            fetch_valid_i <= 1'b0;
            if (fetch_enable && credits > 0 && prog_has(fetch_pc)) begin
                // a set lfsr bit makes an idle cycle
                lfsr = lfsr_next(lfsr);
                if (!lfsr[0]) begin
                    fetch_valid_i <= 1'b1;
                    fetch_i.pc    <= fetch_pc;
                    fetch_i.inst  <= mem[1 + ((fetch_pc - PC_BASE) >> 2)];
                    credits  = credits - 1;
                    fetch_pc = fetch_pc + 4;
                end
            end
        end
    end

    // in-order commit check
    always @(posedge clk) begin
        logic [31:0] e_pc;
        logic [31:0] e_rd;
        logic [31:0] e_data;
        logic [31:0] e_next;
        logic        e_redirect;
        if (!reset_i && !commit_valid_o && redirect_valid_o) begin
            $display("redirect raised without a commit, pc %h", redirect_pc_o);
            errors++;
        end
        if (!reset_i && commit_valid_o) begin
            e_pc   = mem[EXP_BASE + 3 * exp_idx];
            e_rd   = mem[EXP_BASE + 3 * exp_idx + 1];
            e_data = mem[EXP_BASE + 3 * exp_idx + 2];
            tests++;
            if (e_pc == MARKER) begin
                $display("commit after end of expected list, pc %h", commit_pc_o);
                errors++;
            end else begin
                e_next = mem[EXP_BASE + 3 * exp_idx + 3];
                // a jump in the expected pc sequence means a taken branch here
                e_redirect = (e_next != MARKER) && (e_next != e_pc + 32'd4);
                if (commit_pc_o != e_pc) begin
                    $display("Mismatch commit_%0d pc: expected %h actual %h",
                             exp_idx, e_pc, commit_pc_o);
                    errors++;
                end else if (32'(commit_rd_o) != e_rd) begin
                    $display("Mismatch commit_%0d rd: expected %0d actual %0d",
                             exp_idx, e_rd, commit_rd_o);
                    errors++;
                end else if (commit_data_o != e_data) begin
                    $display("Mismatch commit_%0d data: expected %h actual %h",
                             exp_idx, e_data, commit_data_o);
                    errors++;
                end else if (redirect_valid_o != e_redirect) begin
                    $display("Mismatch commit_%0d redirect: expected %0d actual %0d",
                             exp_idx, e_redirect, redirect_valid_o);
                    errors++;
                end else if (e_redirect && redirect_pc_o != e_next) begin
                    $display("Mismatch commit_%0d redirect_pc: expected %h actual %h",
                             exp_idx, e_next, redirect_pc_o);
                    errors++;
                end else begin
                    $display("test commit_%0d pc %h: ok", exp_idx, e_pc);
                end
                exp_idx++;
            end
        end
    end

    initial begin
        int  cycles;
        errors        = 0;
        tests         = 0;
        exp_idx       = 0;
        credits       = QUEUE_DEPTH;
        fetch_enable  = 1'b0;
        fetch_pc      = PC_BASE;
        lfsr          = 16'd43326;
        reset_i       = 1'b1;
        fetch_valid_i = 1'b0;
        fetch_i       = '0;
        $readmemh("test/backend_patterns.txt", mem);

        repeat (3) @(posedge clk);
        reset_i <= 1'b0;

        // quiet outputs until the first send
        tests++;
        cycles = 0;
        repeat (4) begin
            @(posedge clk);
            if (commit_valid_o || redirect_valid_o || credit_return_o != '0) begin
                cycles++;
            end
        end
        if (cycles != 0) begin
            $display("outputs active after reset before any fetch");
            errors++;
        end else begin
            $display("test reset_state: ok");
        end
        fetch_enable <= 1'b1;

        cycles = 0;
        while (mem[EXP_BASE + 3 * exp_idx] != MARKER && cycles < TIMEOUT) begin
            @(posedge clk);
            cycles++;
        end
        if (cycles >= TIMEOUT) begin
            $display("timeout waiting for commit %0d", exp_idx);
            errors++;
        end

        // all credits must come home
        tests++;
        cycles = 0;
        while (credits != QUEUE_DEPTH && cycles < 50) begin
            @(posedge clk);
            cycles++;
        end
        if (cycles >= 50) begin
            $display("timeout waiting for credits to return, count %0d", credits);
            errors++;
        end else begin
            repeat (20) @(posedge clk);
            if (credits != QUEUE_DEPTH) begin
                $display("Mismatch credit_drain: expected %0d actual %0d",
                         QUEUE_DEPTH, credits);
                errors++;
            end else begin
                $display("test credit_drain: ok");
            end
        end

        $display("tests: %0d, errors: %0d", tests, errors);
        if (errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* test/backend_patterns.txt */
// word 0: program length, then program words from pc 1c000000
// at 20: expected commits as pc rd value, ended by ffffffff
00000017
02801401 02bff402 00100823 00110464
00120485 00148826 00150827 00158828
142468a9 02801c20 0010040a 58000822
5c000c22 0280040b 0280080c 0280042d
50000c00 0280040b 0280080c 001029ae
580009ce 0280080c ffffffff
@20
1c000000 00000001 00000005
1c000004 00000002 fffffffd
1c000008 00000003 00000002
1c00000c 00000004 fffffffd
1c000010 00000005 00000001
1c000014 00000006 00000005
1c000018 00000007 fffffffd
1c00001c 00000008 fffffff8
1c000020 00000009 12345000
1c000024 00000000 00000000
1c000028 0000000a 00000005
1c00002c 00000000 00000000
1c000030 00000000 00000000
1c00003c 0000000d 00000006
1c000040 00000000 00000000
1c00004c 0000000e 0000000b
1c000050 00000000 00000000
1c000058 00000000 00000000
ffffffff

/* compile.f */
common/backend_pkg.sv
src/regfile.sv
src/decoder.sv
src/dispatch.sv
src/execute.sv
src/ctrl.sv
src/backend_top.sv
test/tb_backend.sv

/* Makefile */
LOG = sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run tb_backend"
	@echo "  clean  remove build output and log"

test:
	verilator --binary --top-module tb_backend -f compile.f -Mdir obj_dir -o vtb
	./obj_dir/vtb | tee $(LOG)
	@if grep -q "Finished with errors" $(LOG); then \
		echo "simulation failed"; exit 1; \
	fi
	@grep -q "Finished with no errors" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
